//--- Makefile
VERILATOR ?= verilator
TOP       := execute_stage_tb
FILELIST  := execute_stage.f
VFLAGS    := --binary --timing -j 0 --top-module $(TOP)
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell cat $(FILELIST))
PASS_MSG  := Simulation passed

.PHONY: all run clean

all: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- execute_stage.f
source/isa_pkg.sv
source/exec_pkg.sv
source/alu_unit.sv
source/mul_unit.sv
source/lsu_agen.sv
source/branch_unit.sv
source/execute_stage.sv
verification/execute_stage_tb.sv

//--- source/alu_unit.sv
`timescale 1ns/100ps
`default_nettype none

module alu_unit (
  input  exec_pkg::issue_packet_t req_i,
  output exec_pkg::word_t         result_o
);
  import exec_pkg::*;
  import isa_pkg::*;

  logic [SHAMT_W-1:0] shamt;

  assign shamt = req_i.opb[SHAMT_W-1:0];  // Low bits only, as in RV32I

  always_comb begin
    case (req_i.alu_op)
      ALU_ADD: begin
        result_o = req_i.opa + req_i.opb;
      end
      ALU_SUB: begin
        result_o = req_i.opa - req_i.opb;
      end
      ALU_AND: begin
        result_o = req_i.opa & req_i.opb;
      end
      ALU_OR: begin
        result_o = req_i.opa | req_i.opb;
      end
      ALU_XOR: begin
        result_o = req_i.opa ^ req_i.opb;
      end
      ALU_SLT: begin
        result_o = word_t'($signed(req_i.opa) < $signed(req_i.opb));
      end
      ALU_SLTU: begin
        result_o = word_t'(req_i.opa < req_i.opb);
      end
      ALU_SLL: begin
        result_o = req_i.opa << shamt;
      end
      ALU_SRL: begin
        result_o = req_i.opa >> shamt;
      end
      ALU_SRA: begin
        result_o = word_t'($signed(req_i.opa) >>> shamt);  // Keeps sign bit
      end
      default: begin
        result_o = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- source/branch_unit.sv
`timescale 1ns/100ps
`default_nettype none

module branch_unit (
  input  exec_pkg::issue_packet_t req_i,
  output exec_pkg::completion_t   complete_o
);
  import exec_pkg::*;
  import isa_pkg::*;

  br_func_e func;
  word_t    target;
  logic     taken;

  // Target from the shared ALU, operands set up at issue
  alu_unit u_target_alu (
    .req_i    (req_i),
    .result_o (target)
  );

  assign func = br_func_e'(req_i.inst.b.funct3);

  always_comb begin
    taken = 1'b0;
    if (req_i.uncond_branch) begin
      taken = 1'b1;  // JAL and JALR
    end else begin
      case (func)
        BR_BEQ:  taken = (req_i.rs1_val == req_i.rs2_val);
        BR_BNE:  taken = (req_i.rs1_val != req_i.rs2_val);
        BR_BLT:  taken = ($signed(req_i.rs1_val) <  $signed(req_i.rs2_val));
        BR_BGE:  taken = ($signed(req_i.rs1_val) >= $signed(req_i.rs2_val));
        BR_BLTU: taken = (req_i.rs1_val <  req_i.rs2_val);
        BR_BGEU: taken = (req_i.rs1_val >= req_i.rs2_val);
        default: taken = 1'b0;
      endcase
    end
  end

  // ======================================================================
  // Completion slot
  // ======================================================================

  always_comb begin
    complete_o = '0;
    if (req_i.valid) begin
      complete_o.valid        = 1'b1;
      complete_o.value        = target;
      complete_o.dest_prf     = req_i.dest_tag;  // Link register for jumps
      complete_o.rob_idx      = req_i.rob_idx;
      complete_o.branch_taken = taken;
      complete_o.is_jump      = req_i.uncond_branch;
      complete_o.npc          = req_i.npc;
    end
  end

endmodule

`default_nettype wire

//--- source/exec_pkg.sv
`default_nettype none

package exec_pkg;

  // ======================================================================
  // Datapath and machine sizes
  // ======================================================================

  localparam int XLEN    = 32;
  localparam int SHAMT_W = 5;

  localparam int PHYS_REGS = 128;
  localparam int ROB_DEPTH = 64;

  localparam int PRF_TAG_W = $clog2(PHYS_REGS);
  localparam int ROB_IDX_W = $clog2(ROB_DEPTH);

  // Multiplier latency in cycles
  localparam int MULT_STAGES = 4;

  typedef logic [XLEN-1:0]      word_t;
  typedef logic [PRF_TAG_W-1:0] prf_tag_t;
  typedef logic [ROB_IDX_W-1:0] rob_idx_t;

  // ======================================================================
  // Issue side
  // ======================================================================

  typedef struct packed {
    logic              valid;          // Single-cycle strobe
    isa_pkg::inst_t    inst;
    isa_pkg::alu_op_e  alu_op;
    word_t             opa;            // After operand mux
    word_t             opb;
    word_t             rs1_val;        // Raw register values
    word_t             rs2_val;
    word_t             imm;
    word_t             npc;
    prf_tag_t          dest_tag;
    rob_idx_t          rob_idx;
    logic              rd_mem;
    logic              wr_mem;
    logic              uncond_branch;
  } issue_packet_t;

  // ======================================================================
  // Completion bus and load/store queue port
  // ======================================================================

  typedef struct packed {
    logic     valid;
    word_t    value;
    prf_tag_t dest_prf;
    rob_idx_t rob_idx;
    logic     branch_taken;
    logic     is_jump;
    word_t    npc;
  } completion_t;

  typedef struct packed {
    logic                         valid;
    logic                         is_load;
    logic                         is_store;
    rob_idx_t                     rob_idx;
    prf_tag_t                     dest_prf;    // Loads only
    word_t                        addr;
    word_t                        store_data;  // Stores only
    logic [isa_pkg::FUNCT3_W-1:0] funct3;      // Load width and sign
  } lsq_req_t;

  // Slot order on the completion bus
  localparam int CMPL_ALU   = 0;
  localparam int CMPL_MUL   = 1;
  localparam int CMPL_BR    = 2;
  localparam int CMPL_SLOTS = 3;

endpackage

`default_nettype wire

//--- source/execute_stage.sv
`timescale 1ns/100ps
`default_nettype none

module execute_stage (
  input  logic                                              clock,
  input  logic                                              reset,
  input  exec_pkg::issue_packet_t                           alu_req_i,
  input  exec_pkg::issue_packet_t                           mul_req_i,
  input  exec_pkg::issue_packet_t                           lsu_req_i,
  input  exec_pkg::issue_packet_t                           br_req_i,
  output exec_pkg::completion_t [exec_pkg::CMPL_SLOTS-1:0]  complete_o,
  output exec_pkg::lsq_req_t                                lsq_o
);
  import exec_pkg::*;

  word_t alu_result;

  // ======================================================================
  // Functional units
  // ======================================================================

  alu_unit u_alu (
    .req_i    (alu_req_i),
    .result_o (alu_result)
  );

  mul_unit u_mul (
    .clock      (clock),
    .reset      (reset),
    .req_i      (mul_req_i),
    .complete_o (complete_o[CMPL_MUL])  // Four cycles behind its request
  );

  lsu_agen u_lsu (
    .req_i (lsu_req_i),
    .lsq_o (lsq_o)
  );

  branch_unit u_br (
    .req_i      (br_req_i),
    .complete_o (complete_o[CMPL_BR])
  );

  // ======================================================================
  // ALU completion slot
  // ======================================================================

  always_comb begin
    complete_o[CMPL_ALU] = '0;
    if (alu_req_i.valid) begin
      complete_o[CMPL_ALU].valid    = 1'b1;
      complete_o[CMPL_ALU].value    = alu_result;
      complete_o[CMPL_ALU].dest_prf = alu_req_i.dest_tag;
      complete_o[CMPL_ALU].rob_idx  = alu_req_i.rob_idx;
      complete_o[CMPL_ALU].npc      = alu_req_i.npc;
    end
  end

endmodule

`default_nettype wire

//--- source/isa_pkg.sv
`default_nettype none

package isa_pkg;

  localparam int FUNCT3_W = 3;

  // ======================================================================
  // Instruction formats
  // ======================================================================

  typedef struct packed {
    logic [6:0]          funct7;
    logic [4:0]          rs2;
    logic [4:0]          rs1;
    logic [FUNCT3_W-1:0] funct3;
    logic [4:0]          rd;
    logic [6:0]          opcode;
  } inst_r_t;

  typedef struct packed {
    logic [11:0]         imm;
    logic [4:0]          rs1;
    logic [FUNCT3_W-1:0] funct3;
    logic [4:0]          rd;
    logic [6:0]          opcode;
  } inst_i_t;

  typedef struct packed {
    logic                imm_12;
    logic [5:0]          imm_10_5;
    logic [4:0]          rs2;
    logic [4:0]          rs1;
    logic [FUNCT3_W-1:0] funct3;
    logic [3:0]          imm_4_1;
    logic                imm_11;
    logic [6:0]          opcode;
  } inst_b_t;

  // Same 32-bit word, three decodings
  typedef union packed {
    inst_r_t r;
    inst_i_t i;
    inst_b_t b;
  } inst_t;

  // ======================================================================
  // Functional unit encodings
  // ======================================================================

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
    ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA
  } alu_op_e;

  // Values follow funct3 of the M extension
  typedef enum logic [FUNCT3_W-1:0] {
    MUL_MUL = 3'd0, MUL_MULH = 3'd1, MUL_MULHSU = 3'd2, MUL_MULHU = 3'd3
  } mul_func_e;

  typedef enum logic [FUNCT3_W-1:0] {
    BR_BEQ  = 3'b000, BR_BNE  = 3'b001, BR_BLT  = 3'b100,
    BR_BGE  = 3'b101, BR_BLTU = 3'b110, BR_BGEU = 3'b111
  } br_func_e;

endpackage

`default_nettype wire

//--- source/lsu_agen.sv
`timescale 1ns/100ps
`default_nettype none

module lsu_agen (
  input  exec_pkg::issue_packet_t req_i,
  output exec_pkg::lsq_req_t      lsq_o
);
  import exec_pkg::*;

  word_t offset;
  word_t addr;

  // Sign-extended 12-bit displacement
  assign offset = {{(XLEN-12){req_i.imm[11]}}, req_i.imm[11:0]};
  assign addr   = req_i.rs1_val + offset;

  always_comb begin
    lsq_o = '0;
    if (req_i.valid && req_i.rd_mem) begin
      lsq_o.valid    = 1'b1;
      lsq_o.is_load  = 1'b1;
      lsq_o.rob_idx  = req_i.rob_idx;
      lsq_o.dest_prf = req_i.dest_tag;
      lsq_o.addr     = addr;
      lsq_o.funct3   = req_i.inst.i.funct3;  // Byte, half or word, signed or not
    end else if (req_i.valid && req_i.wr_mem) begin
      lsq_o.valid      = 1'b1;
      lsq_o.is_store   = 1'b1;
      lsq_o.rob_idx    = req_i.rob_idx;
      lsq_o.addr       = addr;
      lsq_o.store_data = req_i.rs2_val;
    end
    // Neither kind leaves the port idle
  end

endmodule

`default_nettype wire

//--- source/mul_unit.sv
`timescale 1ns/100ps
`default_nettype none

module mul_unit (
  input  logic                    clock,
  input  logic                    reset,
  input  exec_pkg::issue_packet_t req_i,
  output exec_pkg::completion_t   complete_o
);
  import exec_pkg::*;
  import isa_pkg::*;

  // Bookkeeping that rides along with each product
  typedef struct packed {
    prf_tag_t dest_prf;
    rob_idx_t rob_idx;
    logic     upper;     // Return the high word
  } mul_tag_t;

  mul_func_e                           func;
  logic                                a_signed;
  logic                                b_signed;
  logic [2*XLEN-1:0]                   opa_ext;
  logic [2*XLEN-1:0]                   opb_ext;
  mul_tag_t                            tag_d;

  logic [MULT_STAGES-1:0]              valid_q;
  mul_tag_t [MULT_STAGES-1:0]          tag_q;
  logic [2*XLEN-1:0]                   opa_q;
  logic [2*XLEN-1:0]                   opb_q;
  logic [MULT_STAGES-1:1][2*XLEN-1:0]  prod_q;

  // ======================================================================
  // Operand extension
  // ======================================================================

  assign func     = mul_func_e'(req_i.inst.r.funct3);
  assign a_signed = (func == MUL_MULH) || (func == MUL_MULHSU);
  assign b_signed = (func == MUL_MULH);

  assign opa_ext = {{XLEN{a_signed & req_i.rs1_val[XLEN-1]}}, req_i.rs1_val};
  assign opb_ext = {{XLEN{b_signed & req_i.rs2_val[XLEN-1]}}, req_i.rs2_val};

  assign tag_d.dest_prf = req_i.dest_tag;
  assign tag_d.rob_idx  = req_i.rob_idx;
  assign tag_d.upper    = (func != MUL_MUL);

  // ======================================================================
  // Pipeline
  // ======================================================================

  always_ff @(posedge clock) begin
    if (reset) begin
      valid_q <= '0;
    end else begin
      valid_q <= {valid_q[MULT_STAGES-2:0], req_i.valid};
    end
  end

  always_ff @(posedge clock) begin
    opa_q    <= opa_ext;   // Stage 0
    opb_q    <= opb_ext;
    tag_q[0] <= tag_d;
    prod_q[1] <= opa_q * opb_q;  // Low 64 bits cover every variant
    for (int i = 1; i < MULT_STAGES; i++) begin
      tag_q[i] <= tag_q[i-1];
    end
    for (int i = 2; i < MULT_STAGES; i++) begin
      prod_q[i] <= prod_q[i-1];
    end
  end

  always_comb begin
    complete_o = '0;
    if (valid_q[MULT_STAGES-1]) begin
      complete_o.valid    = 1'b1;
      complete_o.value    = tag_q[MULT_STAGES-1].upper ?
                            prod_q[MULT_STAGES-1][2*XLEN-1:XLEN] :
                            prod_q[MULT_STAGES-1][XLEN-1:0];
      complete_o.dest_prf = tag_q[MULT_STAGES-1].dest_prf;
      complete_o.rob_idx  = tag_q[MULT_STAGES-1].rob_idx;
    end
  end

endmodule

`default_nettype wire

//--- verification/execute_stage_tb.sv
`timescale 1ns/100ps
`default_nettype none

module execute_stage_tb;
  import exec_pkg::*;
  import isa_pkg::*;

  localparam int CLK_PERIOD   = 10;
  localparam int RESET_CYCLES = 4;
  localparam int IDLE_CYCLES  = 8;
  localparam int N_ALU        = 200;
  localparam int N_MUL        = 48;
  localparam int N_LSU        = 36;
  localparam int BR_PAIRS     = 6;
  localparam int N_BR         = BR_PAIRS * 9;  // Eight funct3 codes and one jump per pair
  localparam int DRAIN        = MULT_STAGES + 2;
  localparam int TEST_CYCLES  = IDLE_CYCLES + N_ALU + N_MUL + N_LSU + N_BR + 5 * DRAIN;
  localparam int WATCHDOG_NS  = (RESET_CYCLES + TEST_CYCLES) * CLK_PERIOD + 500;

  logic                         clock;
  logic                         reset;
  issue_packet_t                alu_req;
  issue_packet_t                mul_req;
  issue_packet_t                lsu_req;
  issue_packet_t                br_req;
  completion_t [CMPL_SLOTS-1:0] complete;
  lsq_req_t                     lsq;

  logic [31:0]  rng_state;
  logic         checking;
  int           checks;
  int           errors;
  completion_t  mul_expect_q[$];   // One entry per pipeline stage

  // Boundary operand pairs for the branch compares
  word_t br_a [BR_PAIRS] = '{32'd5, 32'h8000_0000, 32'h7fff_ffff,
                             32'hffff_ffff, 32'd0, 32'h8000_0000};
  word_t br_b [BR_PAIRS] = '{32'd5, 32'h7fff_ffff, 32'h8000_0000,
                             32'd0, 32'hffff_ffff, 32'h8000_0000};

  execute_stage dut_i (
    .clock      (clock),
    .reset      (reset),
    .alu_req_i  (alu_req),
    .mul_req_i  (mul_req),
    .lsu_req_i  (lsu_req),
    .br_req_i   (br_req),
    .complete_o (complete),
    .lsq_o      (lsq)
  );

  always #(CLK_PERIOD / 2) clock = ~clock;

  // ====================================================================
  // Reference model
  // ====================================================================

  function automatic logic signed_less(input word_t a, input word_t b);
    return (a[31] != b[31]) ? a[31] : (a < b);  // Sign bits decide when they differ
  endfunction

  function automatic word_t alu_value(input issue_packet_t req);
    logic [4:0]  sh;
    logic [63:0] wide;
    sh   = req.opb[4:0];
    wide = {{32{req.opa[31]}}, req.opa} >> sh;
    case (req.alu_op)
      ALU_ADD:  return req.opa + req.opb;
      ALU_SUB:  return req.opa + ~req.opb + 32'd1;
      ALU_AND:  return req.opa & req.opb;
      ALU_OR:   return req.opa | req.opb;
      ALU_XOR:  return req.opa ^ req.opb;
      ALU_SLT:  return {31'd0, signed_less(req.opa, req.opb)};
      ALU_SLTU: return {31'd0, req.opa < req.opb};
      ALU_SLL:  return req.opa << sh;
      ALU_SRL:  return req.opa >> sh;
      ALU_SRA:  return wide[31:0];
      default:  return '0;
    endcase
  endfunction

  function automatic completion_t alu_completion(input issue_packet_t req);
    completion_t c;
    c = '0;
    if (req.valid) begin
      c.valid    = 1'b1;
      c.value    = alu_value(req);
      c.dest_prf = req.dest_tag;
      c.rob_idx  = req.rob_idx;
      c.npc      = req.npc;
    end
    return c;
  endfunction

  function automatic completion_t mul_completion(input issue_packet_t req);
    completion_t c;
    logic [31:0] word;
    logic [63:0] prod;
    longint      sa;
    c    = '0;
    word = req.inst;
    sa   = longint'($signed(req.rs1_val));
    case (word[14:12])
      3'd0, 3'd1: prod = sa * longint'($signed(req.rs2_val));
      3'd2:       prod = sa * longint'({32'd0, req.rs2_val});
      default:    prod = {32'd0, req.rs1_val} * {32'd0, req.rs2_val};
    endcase
    if (req.valid) begin
      c.valid    = 1'b1;
      c.value    = (word[14:12] == 3'd0) ? prod[31:0] : prod[63:32];
      c.dest_prf = req.dest_tag;
      c.rob_idx  = req.rob_idx;
    end
    return c;
  endfunction

  function automatic completion_t branch_completion(input issue_packet_t req);
    completion_t c;
    logic [31:0] word;
    logic        taken;
    c    = '0;
    word = req.inst;
    case (word[14:12])
      3'b000:  taken = (req.rs1_val == req.rs2_val);
      3'b001:  taken = (req.rs1_val != req.rs2_val);
      3'b100:  taken = signed_less(req.rs1_val, req.rs2_val);
      3'b101:  taken = !signed_less(req.rs1_val, req.rs2_val);
      3'b110:  taken = (req.rs1_val < req.rs2_val);
      3'b111:  taken = !(req.rs1_val < req.rs2_val);
      default: taken = 1'b0;
    endcase
    if (req.valid) begin
      c.valid        = 1'b1;
      c.value        = alu_value(req);
      c.dest_prf     = req.dest_tag;
      c.rob_idx      = req.rob_idx;
      c.branch_taken = taken | req.uncond_branch;
      c.is_jump      = req.uncond_branch;
      c.npc          = req.npc;
    end
    return c;
  endfunction

  function automatic lsq_req_t lsq_request(input issue_packet_t req);
    lsq_req_t    r;
    logic [31:0] word;
    r    = '0;
    word = req.inst;
    if (req.valid && (req.rd_mem || req.wr_mem)) begin
      r.valid   = 1'b1;
      r.rob_idx = req.rob_idx;
      r.addr    = req.rs1_val + {{20{req.imm[11]}}, req.imm[11:0]};
      if (req.rd_mem) begin
        r.is_load  = 1'b1;
        r.dest_prf = req.dest_tag;
        r.funct3   = word[14:12];
      end else begin
        r.is_store   = 1'b1;
        r.store_data = req.rs2_val;
      end
    end
    return r;
  endfunction

  // ====================================================================
  // Checking
  // ====================================================================

  task automatic check_value(input logic [127:0] got, input logic [127:0] expected,
                             input string what);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("ERROR at %0t ns: %s mismatch, got %h expected %h", $time, what, got, expected);
    end
  endtask

  task automatic compare_outputs();
    completion_t expect_mul;
    expect_mul = mul_expect_q.pop_front();
    mul_expect_q.push_back(mul_completion(mul_req));
    check_value(128'(complete[CMPL_ALU]), 128'(alu_completion(alu_req)), "ALU slot");
    check_value(128'(complete[CMPL_MUL]), 128'(expect_mul), "MUL slot");
    check_value(128'(complete[CMPL_BR]), 128'(branch_completion(br_req)), "BR slot");
    check_value(128'(lsq), 128'(lsq_request(lsu_req)), "LSQ port");
  endtask

  always begin
    @(negedge clock);
    #4;  // Just ahead of the next rising edge
    if (checking) begin
      compare_outputs();
    end
  end

  // ====================================================================
  // Stimulus helpers
  // ====================================================================

  function automatic logic [31:0] rand32();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic issue_packet_t random_packet();
    issue_packet_t p;
    p          = '0;
    p.valid    = 1'b1;
    p.inst     = rand32();
    p.opa      = rand32();
    p.opb      = rand32();
    p.rs1_val  = rand32();
    p.rs2_val  = rand32();
    p.imm      = rand32();   // Upper bits must be ignored by the address adder
    p.npc      = rand32();
    p.dest_tag = prf_tag_t'(rand32());
    p.rob_idx  = rob_idx_t'(rand32());
    return p;
  endfunction

  task automatic clear_requests();
    alu_req = '0;
    mul_req = '0;
    lsu_req = '0;
    br_req  = '0;
  endtask

  task automatic idle_cycles(input int n);
    clear_requests();
    repeat (n) @(negedge clock);
  endtask

  task automatic report_test(input string name, input int err_mark);
    if (errors == err_mark) begin
      $display("Test %-14s finished with no mismatches", name);
    end else begin
      $display("Test %-14s finished with %0d mismatches", name, errors - err_mark);
    end
  endtask

  // ====================================================================
  // Test sequence
  // ====================================================================

  initial begin
    int            err_mark;
    issue_packet_t p;
    clock     = 1'b0;
    reset     = 1'b1;
    checking  = 1'b0;
    checks    = 0;
    errors    = 0;
    rng_state = 32'd1611;
    clear_requests();
    repeat (MULT_STAGES) mul_expect_q.push_back(completion_t'('0));  // Empty pipeline
    // Products issued under reset must never reach the output
    repeat (RESET_CYCLES) begin
      mul_req = random_packet();
      @(negedge clock);
    end
    clear_requests();
    reset    = 1'b0;
    checking = 1'b1;

    err_mark = errors;
    idle_cycles(IDLE_CYCLES);
    report_test("reset_idle", err_mark);

    err_mark = errors;
    for (int i = 0; i < N_ALU; i++) begin
      p        = random_packet();
      p.alu_op = alu_op_e'(4'(i % 10));
      alu_req  = p;
      @(negedge clock);
    end
    idle_cycles(DRAIN);
    report_test("alu_random", err_mark);

    err_mark = errors;
    for (int i = 0; i < N_MUL; i++) begin
      p               = random_packet();
      p.inst.r.funct3 = 3'(i % 4);
      if (i < 8) begin
        p.rs1_val = 32'h8000_0000;  // Most negative operand first
        p.rs2_val = (i < 4) ? 32'h8000_0000 : 32'hffff_ffff;
      end
      mul_req = p;
      @(negedge clock);
    end
    idle_cycles(DRAIN);
    report_test("mul_pipeline", err_mark);

    err_mark = errors;
    for (int i = 0; i < N_LSU; i++) begin
      p        = random_packet();
      p.rd_mem = (i % 3 == 0);
      p.wr_mem = (i % 3 == 1);
      lsu_req  = p;
      @(negedge clock);
    end
    idle_cycles(DRAIN);
    report_test("lsu_agen", err_mark);

    err_mark = errors;
    for (int k = 0; k < BR_PAIRS; k++) begin
      for (int f = 0; f < 9; f++) begin
        p         = random_packet();
        p.rs1_val = br_a[k];
        p.rs2_val = br_b[k];
        p.alu_op  = ALU_ADD;        // Target is npc style base plus offset
        if (f == 8) begin
          p.uncond_branch = 1'b1;
        end else begin
          p.inst.b.funct3 = 3'(f);  // Codes 2 and 3 are not branches
        end
        br_req = p;
        @(negedge clock);
      end
    end
    idle_cycles(DRAIN);
    report_test("branch", err_mark);

    checking = 1'b0;
    $display("Checks run: %0d, mismatches: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: tests did not finish within %0d ns", WATCHDOG_NS);
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire
